//--- exe_muldiv_top.f
+incdir+.
muldiv_pkg.sv
mult_pipe.sv
div_iter.sv
muldiv_core.sv
hilo_regs.sv
exe_muldiv_top.sv
tb_exe_muldiv.sv

//--- Bender.yml
package:
  name: exe_muldiv

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - muldiv_pkg.sv
      - mult_pipe.sv
      - div_iter.sv
      - muldiv_core.sv
      - hilo_regs.sv
      - exe_muldiv_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exe_muldiv.sv

//--- tb_exe_muldiv.sv
`timescale 1ns/1ps
`include "muldiv_params.svh"

module tb_exe_muldiv import muldiv_pkg::*; ();

    localparam int W       = `MD_XLEN;
    localparam int TIMEOUT = 4 * `MD_DIV_STEPS;

    logic         clk;
    logic         rst;
    logic         flush;
    md_op_e       op;
    logic [W-1:0] src_a;
    logic [W-1:0] src_b;
    logic         finish;
    logic         stall;
    hilo_t        hilo;

    logic [63:0]  model;  // expected {hi, lo}
    int           errors;
    int           tests;
    int           seed;
    logic [31:0]  corners [8] = '{32'h0, 32'h1, 32'h2, 32'h7, 32'hffff_fff9,
                                  32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};

    exe_muldiv_top exe_muldiv_top_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .op     (op),
        .src_a  (src_a),
        .src_b  (src_b),
        .finish (finish),
        .stall  (stall),
        .hilo   (hilo)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic drive(input md_op_e o, input logic [W-1:0] a, input logic [W-1:0] b);
        @(posedge clk);
        #1;
        op    = o;
        src_a = a;
        src_b = b;
    endtask

    function automatic logic [63:0] mul_ref(input md_op_e o, input logic [31:0] a,
                                            input logic [31:0] b);
        if (o inside {MD_MULT, MD_MADD, MD_MSUB}) begin
            return longint'($signed(a)) * longint'($signed(b));
        end
        return {32'h0, a} * {32'h0, b};
    endfunction

    // {remainder, quotient} of a truncating division
    function automatic logic [63:0] div_ref(input bit sgn, input logic [31:0] a,
                                            input logic [31:0] b);
        longint na;
        longint nb;
        if (b == '0) begin
            return {a, 32'hffff_ffff};  // sign fix of |a| gives a back
        end
        na = sgn ? longint'($signed(a)) : longint'(a);
        nb = sgn ? longint'($signed(b)) : longint'(b);
        return {32'(na % nb), 32'(na / nb)};
    endfunction

    // run one op to finish, then NOP and compare HI/LO
    task automatic run_op(input md_op_e o, input logic [W-1:0] a, input logic [W-1:0] b,
                          output int cycles);
        bit done;
        cycles = 0;
        done   = 1'b0;
        drive(o, a, b);
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            done = finish;
            if (done) begin
                check("stall", stall, 0);  // released in the finish cycle
            end else begin
                check("stall", stall, 1);
            end
        end
        if (!done) begin
            $display("ERROR at %0t: finish never came for %s", $time, o.name());
            errors++;
        end
        drive(MD_NOP, '0, '0);
        @(negedge clk);
        check("hilo", hilo, model);
    endtask

    task automatic mul_op(input md_op_e o, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p;
        int          cycles;
        p = mul_ref(o, a, b);
        case (o)
            MD_MADD, MD_MADDU: model = model + p;
            MD_MSUB, MD_MSUBU: model = model - p;
            default:           model = p;
        endcase
        run_op(o, a, b, cycles);
        check("finish latency", cycles, 2);
    endtask

    task automatic div_op(input md_op_e o, input logic [31:0] a, input logic [31:0] b);
        int cycles;
        model = div_ref(o == MD_DIV, a, b);
        run_op(o, a, b, cycles);
    endtask

    task automatic move_to(input md_op_e o, input logic [31:0] v);
        drive(o, v, 32'h0);
        @(negedge clk);
        check("stall", stall, 0);
        check("finish", finish, 0);
        if (o == MD_MTHI) begin
            model[63:32] = v;
        end else begin
            model[31:0] = v;
        end
        drive(MD_NOP, '0, '0);
        @(negedge clk);
        check("hilo", hilo, model);
    endtask

    // pipeline drops the op and flushes for one cycle
    task automatic flush_now();
        drive(MD_NOP, '0, '0);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        repeat (`MD_DIV_STEPS + 4) begin
            @(negedge clk);
            check("stall", stall, 0);
            check("finish", finish, 0);
        end
        check("hilo", hilo, model);
    endtask

    task automatic test_reset_move();
        int e0;
        e0 = errors;
        @(negedge clk);
        check("hilo", hilo, 64'h0);
        check("stall", stall, 0);
        check("finish", finish, 0);
        move_to(MD_MTHI, 32'hdead_beef);
        move_to(MD_MTLO, 32'h0bad_cafe);
        move_to(MD_MTHI, 32'h1357_9bdf);
        report("reset_move", e0);
    endtask

    task automatic test_mult();
        int e0;
        e0 = errors;
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                mul_op(MD_MULT, corners[i], corners[j]);
                mul_op(MD_MULTU, corners[i], corners[j]);
            end
        end
        repeat (16) begin
            mul_op(MD_MULT, $random(seed), $random(seed));
            mul_op(MD_MULTU, $random(seed), $random(seed));
        end
        report("mult", e0);
    endtask

    task automatic test_madd();
        int e0;
        e0 = errors;
        repeat (6) begin
            move_to(MD_MTHI, $random(seed));
            move_to(MD_MTLO, $random(seed));
            mul_op(MD_MADD, $random(seed), $random(seed));
            mul_op(MD_MADDU, $random(seed), $random(seed));
            mul_op(MD_MSUB, $random(seed), $random(seed));
            mul_op(MD_MSUBU, $random(seed), $random(seed));
        end
        move_to(MD_MTLO, 32'h0000_0001);
        mul_op(MD_MSUB, 32'h8000_0000, 32'hffff_ffff);  // borrow across the words
        report("madd_msub", e0);
    endtask

    task automatic test_div();
        int e0;
        e0 = errors;
        foreach (corners[i]) begin
            for (int j = 1; j < 8; j++) begin
                div_op(MD_DIV, corners[i], corners[j]);
                div_op(MD_DIVU, corners[i], corners[j]);
            end
        end
        repeat (12) begin
            div_op(MD_DIV, $random(seed), $random(seed) >>> 8);
            div_op(MD_DIVU, $random(seed), $random(seed) & 32'h0000_ffff);
        end
        report("div", e0);
    endtask

    task automatic test_div_zero();
        int e0;
        e0 = errors;
        foreach (corners[i]) begin
            div_op(MD_DIV, corners[i], 32'h0);
            div_op(MD_DIVU, corners[i], 32'h0);
        end
        report("div_zero", e0);
    endtask

    task automatic test_flush();
        int e0;
        e0 = errors;
        move_to(MD_MTHI, 32'h1111_2222);
        move_to(MD_MTLO, 32'h3333_4444);
        drive(MD_DIV, 32'd1000, 32'd7);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check("stall", stall, 1);  // divider mid-run
        flush_now();
        drive(MD_MULT, 32'hffff_fff0, 32'd3);
        flush_now();
        mul_op(MD_MULT, 32'hffff_fff0, 32'd3);
        div_op(MD_DIV, 32'd1000, 32'hffff_fff9);
        report("flush", e0);
    endtask

    initial begin
        seed   = 32'hf6d7;
        rst    = 1'b1;
        flush  = 1'b0;
        op     = MD_NOP;
        src_a  = '0;
        src_b  = '0;
        model  = '0;
        errors = 0;
        tests  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_move();
        test_mult();
        test_madd();
        test_div();
        test_div_zero();
        test_flush();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- exe_muldiv_top.sv
`timescale 1ns/1ps
`include "muldiv_params.svh"

module exe_muldiv_top import muldiv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  md_op_e              op,
    input  logic [`MD_XLEN-1:0] src_a,
    input  logic [`MD_XLEN-1:0] src_b,
    output logic                finish,
    output logic                stall,
    output hilo_t               hilo
);

    md_result_t result;  // core to HI/LO write request

    muldiv_core muldiv_core_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .op     (op),
        .src_a  (src_a),
        .src_b  (src_b),
        .result (result),
        .finish (finish),
        .stall  (stall)
    );

    hilo_regs hilo_regs_inst (
        .clk    (clk),
        .rst    (rst),
        .op     (op),
        .src_a  (src_a),
        .result (result),
        .hilo   (hilo)
    );

endmodule

//--- hilo_regs.sv
`timescale 1ns/1ps
`include "muldiv_params.svh"

module hilo_regs import muldiv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  md_op_e              op,
    input  logic [`MD_XLEN-1:0] src_a,
    input  md_result_t          result,
    output hilo_t               hilo
);

    logic [2*`MD_XLEN-1:0] cur;
    logic [2*`MD_XLEN-1:0] inc;
    logic [2*`MD_XLEN-1:0] acc_sum;
    logic [2*`MD_XLEN-1:0] acc_diff;

    // accumulate over the full 64-bit pair
    assign cur      = {hilo.hi, hilo.lo};
    assign inc      = {result.hilo.hi, result.hilo.lo};
    assign acc_sum  = cur + inc;
    assign acc_diff = cur - inc;

    always_ff @(posedge clk) begin
        if (rst) begin
            hilo <= '0;
        end else if (result.valid) begin
            case (result.mode)
                ACC_ADD: hilo <= hilo_t'(acc_sum);
                ACC_SUB: hilo <= hilo_t'(acc_diff);
                default: hilo <= result.hilo;
            endcase
        end else if (op == MD_MTHI) begin
            hilo.hi <= src_a;  // lo untouched
        end else if (op == MD_MTLO) begin
            hilo.lo <= src_a;
        end
    end

endmodule

//--- muldiv_core.sv
`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_core import muldiv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  md_op_e              op,
    input  logic [`MD_XLEN-1:0] src_a,
    input  logic [`MD_XLEN-1:0] src_b,
    output md_result_t          result,
    output logic                finish,
    output logic                stall
);

    typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;
    typedef enum logic [1:0] {DIV_IDLE, DIV_START, DIV_WAIT} div_state_e;

    mul_state_e            mul_state;
    mul_state_e            mul_next;
    div_state_e            div_state;
    div_state_e            div_next;
    logic                  is_mul;
    logic                  is_div;
    logic                  is_signed;
    acc_mode_e             acc_mode;
    logic                  mul_finish;
    logic                  div_launch;
    logic                  div_start;
    logic                  div_busy;
    logic                  div_done;
    logic                  div_signed_q;
    logic [`MD_XLEN-1:0]   div_a_q;
    logic [`MD_XLEN-1:0]   div_b_q;
    logic [`MD_XLEN-1:0]   quotient;
    logic [`MD_XLEN-1:0]   remainder;
    logic [2*`MD_XLEN-1:0] product;

    assign is_mul    = op inside {MD_MULT, MD_MULTU, MD_MADD, MD_MADDU, MD_MSUB, MD_MSUBU};
    assign is_div    = op inside {MD_DIV, MD_DIVU};
    assign is_signed = op inside {MD_MULT, MD_MADD, MD_MSUB, MD_DIV};

    always_comb begin
        case (op)
            MD_MADD, MD_MADDU: acc_mode = ACC_ADD;
            MD_MSUB, MD_MSUBU: acc_mode = ACC_SUB;
            default:           acc_mode = ACC_SET;
        endcase
    end

    // multiply sequencing, fixed two cycles
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_state <= MUL_IDLE;
        end else begin
            mul_state <= mul_next;
        end
    end

    always_comb begin
        case (mul_state)
            MUL_IDLE: mul_next = is_mul ? MUL_RUN : MUL_IDLE;
            MUL_RUN:  mul_next = MUL_DONE;
            default:  mul_next = MUL_IDLE;
        endcase
    end

    assign mul_finish = (mul_state == MUL_DONE);

    // divide sequencing
    assign div_launch = (div_state == DIV_IDLE) && is_div && !div_busy;
    assign div_start  = (div_state == DIV_START);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            div_state <= DIV_IDLE;
        end else begin
            div_state <= div_next;
        end
    end

    always_comb begin
        case (div_state)
            DIV_IDLE:  div_next = div_launch ? DIV_START : DIV_IDLE;
            DIV_START: div_next = DIV_WAIT;
            DIV_WAIT:  div_next = div_done ? DIV_IDLE : DIV_WAIT;
            default:   div_next = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (div_launch) begin
            div_a_q      <= src_a;
            div_b_q      <= src_b;
            div_signed_q <= is_signed;
        end
    end

    mult_pipe mult_pipe_inst (
        .clk       (clk),
        .a         (src_a),
        .b         (src_b),
        .is_signed (is_signed),
        .product   (product)
    );

    div_iter div_iter_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .start     (div_start),
        .is_signed (div_signed_q),
        .dividend  (div_a_q),
        .divisor   (div_b_q),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign finish = mul_finish || div_done;
    assign stall  = (is_mul && !mul_finish) || (is_div && !div_done);

    always_comb begin
        result.valid = finish && !flush;  // flushed op never reaches HI/LO
        if (mul_finish) begin
            result.mode = acc_mode;
            result.hilo = hilo_t'(product);
        end else begin
            result.mode    = ACC_SET;
            result.hilo.hi = remainder;  // MIPS layout
            result.hilo.lo = quotient;
        end
    end

endmodule

//--- div_iter.sv
`timescale 1ns/1ps
`include "muldiv_params.svh"

module div_iter (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                start,
    input  logic                is_signed,
    input  logic [`MD_XLEN-1:0] dividend,
    input  logic [`MD_XLEN-1:0] divisor,
    output logic                busy,
    output logic                done,
    output logic [`MD_XLEN-1:0] quotient,
    output logic [`MD_XLEN-1:0] remainder
);

    localparam int W     = `MD_XLEN;
    localparam int CNT_W = $clog2(`MD_DIV_STEPS);

    logic [CNT_W-1:0] cnt;       // steps left after this one
    logic             last_step;
    logic [W-1:0]     dvs_q;     // divisor magnitude
    logic             neg_quo;
    logic             neg_rem;
    logic [W-1:0]     a_abs;
    logic [W-1:0]     b_abs;
    logic [W:0]       shifted;
    logic [W:0]       diff;
    logic [W-1:0]     rem_step;
    logic [W-1:0]     quo_step;

    assign a_abs = (is_signed && dividend[W-1]) ? -dividend : dividend;
    assign b_abs = (is_signed && divisor[W-1]) ? -divisor : divisor;

    // quotient reg doubles as the dividend shift register
    assign shifted   = {remainder, quotient[W-1]};
    assign diff      = shifted - {1'b0, dvs_q};
    assign rem_step  = diff[W] ? shifted[W-1:0] : diff[W-1:0];  // restore on borrow
    assign quo_step  = {quotient[W-2:0], ~diff[W]};
    assign last_step = (cnt == '0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`MD_DIV_STEPS - 1);
            end else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // one-cycle strobe
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            remainder <= '0;
            quotient  <= a_abs;
            dvs_q     <= b_abs;
            // x/0 keeps an all-ones quotient
            neg_quo   <= is_signed && (dividend[W-1] ^ divisor[W-1]) && (divisor != '0);
            neg_rem   <= is_signed && dividend[W-1];  // remainder follows dividend
        end else if (busy) begin
            if (last_step) begin
                // sign fix-up folded into the final step
                remainder <= neg_rem ? -rem_step : rem_step;
                quotient  <= neg_quo ? -quo_step : quo_step;
            end else begin
                remainder <= rem_step;
                quotient  <= quo_step;
            end
        end
    end

endmodule

//--- mult_pipe.sv
`timescale 1ns/1ps
`include "muldiv_params.svh"

module mult_pipe (
    input  logic                  clk,
    input  logic [`MD_XLEN-1:0]   a,
    input  logic [`MD_XLEN-1:0]   b,
    input  logic                  is_signed,
    output logic [2*`MD_XLEN-1:0] product
);

    localparam int W = `MD_XLEN;

    logic [W-1:0]   a_abs;
    logic [W-1:0]   b_abs;
    logic           neg;
    logic [W-1:0]   a_abs_q;
    logic [W-1:0]   b_abs_q;
    logic           neg_q;
    logic [2*W-1:0] raw;

    // magnitudes so the array only has to be unsigned
    assign a_abs = (is_signed && a[W-1]) ? -a : a;
    assign b_abs = (is_signed && b[W-1]) ? -b : b;
    assign neg   = is_signed && (a[W-1] ^ b[W-1]);

    // stage one
    always_ff @(posedge clk) begin
        a_abs_q <= a_abs;
        b_abs_q <= b_abs;
        neg_q   <= neg;
    end

    assign raw = a_abs_q * b_abs_q;  // full 2W-bit product

    // stage two, sign restored
    always_ff @(posedge clk) begin
        if (neg_q) begin
            product <= -raw;
        end else begin
            product <= raw;
        end
    end

endmodule

//--- muldiv_pkg.sv
`include "muldiv_params.svh"

package muldiv_pkg;

    // mul/div operation code held by the pipeline
    typedef enum logic [3:0] {
        MD_NOP   = 4'd0,
        MD_MULT  = 4'd1,
        MD_MULTU = 4'd2,
        MD_MADD  = 4'd3,
        MD_MADDU = 4'd4,
        MD_MSUB  = 4'd5,
        MD_MSUBU = 4'd6,
        MD_DIV   = 4'd7,
        MD_DIVU  = 4'd8,
        MD_MTHI  = 4'd9,
        MD_MTLO  = 4'd10
    } md_op_e;

    // how HI/LO applies a result
    typedef enum logic [1:0] {
        ACC_SET = 2'b00,  // replace
        ACC_ADD = 2'b01,  // madd family
        ACC_SUB = 2'b10   // msub family
    } acc_mode_e;

    typedef struct packed {
        logic [`MD_XLEN-1:0] hi;
        logic [`MD_XLEN-1:0] lo;
    } hilo_t;

    // write request from the core to HI/LO
    typedef struct packed {
        logic      valid;
        acc_mode_e mode;
        hilo_t     hilo;
    } md_result_t;

endpackage

//--- muldiv_params.svh
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// operand width of the mul/div datapath
// multiplier and divider also run at 16 and 64
`define MD_XLEN 32

// restoring divider, one quotient bit per step
`define MD_DIV_STEPS `MD_XLEN

`endif
